//--- common/up_isa_pkg.sv
package up_isa_pkg;

   //////////////////////////////
   // Widths and sizes
   //////////////////////////////

   // One width serves data and addresses.
   localparam int DATA_W   = 8;
   localparam int OP_W     = 4;
   localparam int MEM_SIZE = 256;

   // Execution starts at the high nibble of byte 4, right after the boot values.
   localparam logic [DATA_W-1:0] PC_RESET   = 8'h08;
   localparam logic [DATA_W-1:0] SP_RESET   = 8'hFF;
   localparam logic [DATA_W-1:0] INT_VECTOR = 8'h00;

   //////////////////////////////
   // Opcodes
   //////////////////////////////

   typedef enum logic [OP_W-1:0] {
      OP_ADD   = 4'h0,
      OP_SUB   = 4'h1,
      OP_MUL   = 4'h2,
      OP_NAND  = 4'h3,
      OP_SW01  = 4'h4,
      OP_SW12  = 4'h5,
      OP_SW23  = 4'h6,
      OP_BE    = 4'h7,
      OP_POPC  = 4'h8,
      OP_PUSHC = 4'h9,
      OP_POP   = 4'hA,
      OP_PUSH  = 4'hB,
      OP_LDW   = 4'hC,
      OP_STW   = 4'hD,
      OP_REF   = 4'hE,
      OP_INT   = 4'hF
   } up_op_e;

endpackage

//--- common/up_ctrl_pkg.sv
package up_ctrl_pkg;
   import up_isa_pkg::*;

   typedef enum logic [3:0] {
      LOAD_0 = 4'h0,
      LOAD_1 = 4'h1,
      LOAD_2 = 4'h2,
      LOAD_3 = 4'h3,
      LOAD_4 = 4'h4,
      FETCH  = 4'h5,
      DECODE = 4'h6,
      EXEC_1 = 4'h7,
      EXEC_2 = 4'h8,
      EXEC_3 = 4'h9,
      INT_1  = 4'hA,
      INT_2  = 4'hB,
      INT_3  = 4'hC,
      INT_4  = 4'hD
   } up_state_e;

   // What drives the result bus in a given cycle.
   typedef enum logic [4:0] {
      SRC_CONST, SRC_FETCH_ADDR, SRC_PC, SRC_PC_INC,
      SRC_ADD, SRC_SUB, SRC_MUL, SRC_NAND,
      SRC_X01, SRC_X12, SRC_X23,
      SRC_R2, SRC_R3,
      SRC_SP, SRC_SP_INC, SRC_SP_DEC,
      SRC_MEM
   } up_src_e;

   typedef struct packed {
      up_src_e    src;
      logic [1:0] konst;
      logic       ir_we;
      logic       pc_we;
      logic       sp_we;
      logic       rb_we;
      logic       rb_from_mem;
      logic [1:0] rb_idx;
      logic       mem_we;
      logic       ale;
   } up_ctrl_t;

   typedef struct packed {
      logic [DATA_W-1:0] r0;
      logic [DATA_W-1:0] r1;
      logic [DATA_W-1:0] r2;
      logic [DATA_W-1:0] r3;
   } up_regs_t;

endpackage

//--- verilog/up_memory.sv
`timescale 1ns/1ps

module up_memory
   import up_isa_pkg::*;
(
   input  logic              clk,
   input  logic [DATA_W-1:0] addr,
   input  logic [DATA_W-1:0] result,
   input  logic              mem_we,
   output logic [DATA_W-1:0] rd_data,
   input  logic              map_load,
   input  logic [DATA_W-1:0] map_address,
   input  logic [DATA_W-1:0] map_in,
   output logic [DATA_W-1:0] map_out
);

   logic [DATA_W-1:0] mem [MEM_SIZE];

   // Both read ports are asynchronous.
   assign rd_data = mem[addr];
   assign map_out = mem[map_address];

   always_ff @(posedge clk) begin
      if (mem_we)
         mem[addr] <= result;
      // The host write comes last and wins on the same byte.
      if (map_load)
         mem[map_address] <= map_in;
   end

endmodule

//--- up_core/up_sequencer.sv
`timescale 1ns/1ps

module up_sequencer
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   input  up_regs_t          regs,
   input  logic [DATA_W-1:0] rd_data,
   input  logic              pc0,
   input  logic              int_go,
   output up_ctrl_t          ctrl,
   output logic              int_toggle,
   output logic              int_enter,
   output logic              int_leave
);

   up_state_e  state;
   up_state_e  state_nxt;
   up_op_e     ir;
   logic       zero;
   up_src_e    swap_src;
   logic [1:0] swap_idx;

   assign zero = (regs.r1 == regs.r2);

   // A swap is three xor steps on a register pair, lower index first.
   always_comb begin
      swap_src = SRC_X01;
      swap_idx = 2'd0;
      if (ir == OP_SW12) begin
         swap_src = SRC_X12;
         swap_idx = 2'd1;
      end else if (ir == OP_SW23) begin
         swap_src = SRC_X23;
         swap_idx = 2'd2;
      end
   end

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb begin
      state_nxt = FETCH;
      case (state)
         LOAD_0: state_nxt = LOAD_1;
         LOAD_1: state_nxt = LOAD_2;
         LOAD_2: state_nxt = LOAD_3;
         LOAD_3: state_nxt = LOAD_4;
         FETCH:  state_nxt = int_go ? INT_1 : DECODE;
         DECODE: state_nxt = EXEC_1;
         EXEC_1: begin
            if (!(ir inside {OP_ADD, OP_SUB, OP_MUL, OP_NAND, OP_BE, OP_INT}))
               state_nxt = EXEC_2;
         end
         EXEC_2: begin
            if (ir inside {OP_SW01, OP_SW12, OP_SW23, OP_PUSHC, OP_PUSH})
               state_nxt = EXEC_3;
         end
         INT_1:  state_nxt = INT_2;
         INT_2:  state_nxt = INT_3;
         INT_3:  state_nxt = INT_4;
         default: state_nxt = FETCH;
      endcase
   end

   //////////////////////////////
   // Control word
   //////////////////////////////

   always_comb begin
      ctrl       = '0;
      ctrl.src   = SRC_CONST;
      int_toggle = 1'b0;
      int_enter  = 1'b0;
      int_leave  = 1'b0;
      case (state)
         LOAD_0: ctrl.ale = 1'b1;
         // Boot byte address follows the state encoding.
         LOAD_1, LOAD_2, LOAD_3: begin
            ctrl.konst       = 2'(state);
            ctrl.ale         = 1'b1;
            ctrl.rb_we       = 1'b1;
            ctrl.rb_from_mem = 1'b1;
            ctrl.rb_idx      = 2'(state - LOAD_1);
         end
         LOAD_4: begin
            ctrl.src         = SRC_FETCH_ADDR;
            ctrl.ale         = 1'b1;
            ctrl.rb_we       = 1'b1;
            ctrl.rb_from_mem = 1'b1;
            ctrl.rb_idx      = 2'd3;
         end
         FETCH: begin
            ctrl.src = SRC_FETCH_ADDR;
            ctrl.ale = 1'b1;
         end
         DECODE: begin
            ctrl.src   = SRC_PC_INC;
            ctrl.pc_we = 1'b1;
            ctrl.ir_we = 1'b1;
         end
         EXEC_1: begin
            case (ir)
               OP_ADD:  ctrl.src = SRC_ADD;
               OP_SUB:  ctrl.src = SRC_SUB;
               OP_MUL:  ctrl.src = SRC_MUL;
               OP_NAND: ctrl.src = SRC_NAND;
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.src    = swap_src;
                  ctrl.rb_idx = swap_idx;
               end
               OP_BE: begin
                  ctrl.src   = SRC_R3;
                  ctrl.pc_we = zero;
               end
               OP_POPC, OP_POP: begin
                  ctrl.src   = SRC_SP_INC;
                  ctrl.sp_we = 1'b1;
                  ctrl.ale   = 1'b1;
                  int_leave  = (ir == OP_POPC);
               end
               OP_PUSHC, OP_PUSH: begin
                  ctrl.src = SRC_SP;
                  ctrl.ale = 1'b1;
               end
               OP_LDW, OP_STW: begin
                  ctrl.src = SRC_R3;
                  ctrl.ale = 1'b1;
               end
               OP_REF:  ctrl.ale = 1'b1;
               default: int_toggle = 1'b1;
            endcase
            ctrl.rb_we = (ir inside {OP_ADD, OP_SUB, OP_MUL, OP_NAND,
                                     OP_SW01, OP_SW12, OP_SW23});
         end
         EXEC_2: begin
            case (ir)
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.src    = swap_src;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_idx = swap_idx + 2'd1;
               end
               OP_POPC: begin
                  ctrl.src   = SRC_MEM;
                  ctrl.pc_we = 1'b1;
               end
               OP_PUSHC, OP_PUSH: begin
                  ctrl.src   = SRC_SP_DEC;
                  ctrl.sp_we = 1'b1;
               end
               OP_POP, OP_LDW, OP_REF: begin
                  ctrl.rb_we       = 1'b1;
                  ctrl.rb_from_mem = 1'b1;
                  ctrl.rb_idx      = (ir == OP_REF) ? 2'd0 : 2'd2;
               end
               OP_STW: begin
                  ctrl.src    = SRC_R2;
                  ctrl.mem_we = 1'b1;
               end
               default: ;
            endcase
         end
         EXEC_3: begin
            case (ir)
               OP_PUSH: begin
                  ctrl.src    = SRC_R2;
                  ctrl.mem_we = 1'b1;
               end
               OP_PUSHC: begin
                  ctrl.src    = SRC_PC;
                  ctrl.mem_we = 1'b1;
               end
               default: begin
                  ctrl.src    = swap_src;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_idx = swap_idx;
               end
            endcase
         end
         INT_1: begin
            ctrl.src  = SRC_SP;
            ctrl.ale  = 1'b1;
            int_enter = 1'b1;
         end
         INT_2: begin
            ctrl.src    = SRC_PC;
            ctrl.mem_we = 1'b1;
         end
         INT_3: begin
            ctrl.src   = SRC_SP_DEC;
            ctrl.sp_we = 1'b1;
         end
         INT_4: begin
            ctrl.konst = 2'(INT_VECTOR);
            ctrl.pc_we = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= LOAD_0;
         ir    <= OP_ADD;
      end else begin
         state <= state_nxt;
         // The pc has not moved yet, so bit 0 still picks the nibble.
         if (ctrl.ir_we)
            ir <= up_op_e'(pc0 ? rd_data[OP_W-1:0] : rd_data[DATA_W-1:OP_W]);
      end
   end

   a_state_legal: assert property (@(posedge clk) disable iff (!nRst)
      state inside {[LOAD_0:INT_4]});

   a_fetch_no_store: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.ir_we && ctrl.mem_we));

endmodule

//--- up_core/up_regfile.sv
`timescale 1ns/1ps

module up_regfile
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   input  up_ctrl_t          ctrl,
   input  logic [DATA_W-1:0] rd_data,
   input  logic [DATA_W-1:0] result,
   output up_regs_t          regs
);

   logic [DATA_W-1:0] wr_data;

   // Boot, POP, LDW and REF take the memory byte directly.
   assign wr_data = ctrl.rb_from_mem ? rd_data : result;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs <= '0;
      end else if (ctrl.rb_we) begin
         case (ctrl.rb_idx)
            2'd0:    regs.r0 <= wr_data;
            2'd1:    regs.r1 <= wr_data;
            2'd2:    regs.r2 <= wr_data;
            default: regs.r3 <= wr_data;
         endcase
      end
   end

endmodule

//--- up_core/up_result_unit.sv
`timescale 1ns/1ps

module up_result_unit
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;
(
   input  up_ctrl_t          ctrl,
   input  up_regs_t          regs,
   input  logic [DATA_W-1:0] pc,
   input  logic [DATA_W-1:0] sp,
   input  logic              in_service,
   input  logic [DATA_W-1:0] rd_data,
   output logic [DATA_W-1:0] result
);

   logic [2*DATA_W-1:0] product;

   assign product = regs.r1 * regs.r2;

   always_comb begin
      case (ctrl.src)
         SRC_CONST:      result = DATA_W'(ctrl.konst);
         // pc counts nibbles, the in-service flag picks the handler half.
         SRC_FETCH_ADDR: result = {in_service, pc[DATA_W-1:1]};
         SRC_PC:         result = pc;
         SRC_PC_INC:     result = pc + 1'b1;
         SRC_ADD:        result = regs.r1 + regs.r2;
         SRC_SUB:        result = regs.r1 - regs.r2;
         SRC_MUL:        result = product[DATA_W-1:0];
         SRC_NAND:       result = ~(regs.r1 & regs.r2);
         SRC_X01:        result = regs.r0 ^ regs.r1;
         SRC_X12:        result = regs.r1 ^ regs.r2;
         SRC_X23:        result = regs.r2 ^ regs.r3;
         SRC_R2:         result = regs.r2;
         SRC_R3:         result = regs.r3;
         SRC_SP:         result = sp;
         SRC_SP_INC:     result = sp + 1'b1;
         SRC_SP_DEC:     result = sp - 1'b1;
         SRC_MEM:        result = rd_data;
         default:        result = '0;
      endcase
   end

endmodule

//--- up_core/up_pointer_regs.sv
`timescale 1ns/1ps

module up_pointer_regs
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   input  up_ctrl_t          ctrl,
   input  logic [DATA_W-1:0] result,
   output logic [DATA_W-1:0] pc,
   output logic [DATA_W-1:0] sp,
   output logic [DATA_W-1:0] addr
);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc   <= PC_RESET;
         sp   <= SP_RESET;
         addr <= '0;
      end else begin
         if (ctrl.pc_we)
            pc <= result;
         if (ctrl.sp_we)
            sp <= result;
         if (ctrl.ale)
            addr <= result;
      end
   end

   // Only one value is on the result bus, so pc and sp never load together.
   a_pc_sp_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.pc_we && ctrl.sp_we));

endmodule

//--- up_core/up_int_ctrl.sv
`timescale 1ns/1ps

module up_int_ctrl (
   input  logic clk,
   input  logic nRst,
   input  logic int_req,
   input  logic int_toggle,
   input  logic int_enter,
   input  logic int_leave,
   output logic int_go,
   output logic in_service
);

   logic int_last;
   logic int_en;

   assign int_go = int_req & ~int_last & int_en & ~in_service;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         int_last   <= 1'b0;
         int_en     <= 1'b0;
         in_service <= 1'b0;
      end else begin
         // A pending edge stays visible until the next fetch takes it.
         if (!int_go || int_enter)
            int_last <= int_req;
         if (int_toggle)
            int_en <= ~int_en;
         if (int_enter)
            in_service <= 1'b1;
         else if (int_leave)
            in_service <= 1'b0;
      end
   end

endmodule

//--- up_core/up_core.sv
`timescale 1ns/1ps

module up_core
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              nRst,
   input  logic              int_req,
   input  logic              mem_map_load,
   input  logic [DATA_W-1:0] mem_map_address,
   input  logic [DATA_W-1:0] mem_map_in,
   output logic [DATA_W-1:0] mem_map_out
);

   up_ctrl_t          ctrl;
   up_regs_t          regs;
   logic [DATA_W-1:0] result;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] sp;
   logic [DATA_W-1:0] addr;
   logic              int_go;
   logic              in_service;
   logic              int_toggle;
   logic              int_enter;
   logic              int_leave;

   up_sequencer u_seq (.clk, .nRst, .regs, .rd_data, .pc0(pc[0]), .int_go, .ctrl,
                       .int_toggle, .int_enter, .int_leave);

   up_regfile u_regs (.clk, .nRst, .ctrl, .rd_data, .result, .regs);

   up_result_unit u_res (.ctrl, .regs, .pc, .sp, .in_service, .rd_data, .result);

   up_pointer_regs u_ptr (.clk, .nRst, .ctrl, .result, .pc, .sp, .addr);

   up_int_ctrl u_int (.clk, .nRst, .int_req, .int_toggle, .int_enter, .int_leave,
                      .int_go, .in_service);

   up_memory u_mem (.clk, .addr, .result, .mem_we(ctrl.mem_we), .rd_data,
                    .map_load(mem_map_load), .map_address(mem_map_address),
                    .map_in(mem_map_in), .map_out(mem_map_out));

endmodule

//--- dv/up_core_tests.svh
// Each program ends in a BE to itself with r1 equal to r2, and r3 doubles as a store address.
task automatic test_alu();
   logic [7:0]  a;
   logic [7:0]  b;
   logic [7:0]  expv;
   logic [15:0] prod;
   up_op_e      op;
   for (int i = 0; i < 4; i++) begin
      a    = 8'($random(seed));
      b    = 8'($random(seed));
      prod = 16'(a) * 16'(b);
      op   = up_op_e'(i);
      case (op)
         OP_ADD:  expv = a + b;
         OP_SUB:  expv = a - b;
         OP_MUL:  expv = prod[7:0];
         default: expv = ~(a & b);
      endcase
      new_image(8'h00, a, b, 8'h00);
      emit(op);
      emit(OP_SW01);
      emit(OP_SW12);
      emit(OP_STW);
      emit(OP_SW12);
      emit(OP_LDW);
      image[3] = 8'(npc);
      emit(OP_BE);
      start_image();
      wait_cycles(run_len + MARGIN);
      check_mem(image[3], expv, {"ALU result of ", op.name()});
   end
endtask

task automatic test_swaps();
   up_op_e seq [17];
   seq = '{OP_SW12, OP_SW23, OP_STW, OP_SW01, OP_SW12, OP_SW23, OP_STW, OP_SW01, OP_SW12,
           OP_SW23, OP_STW, OP_SW01, OP_SW12, OP_SW23, OP_STW, OP_SW12, OP_LDW};
   new_image(8'h40, 8'h50, 8'h60, 8'h00);
   foreach (seq[i])
      emit(seq[i]);
   image[3] = 8'(npc);
   emit(OP_BE);
   start_image();
   wait_cycles(run_len + MARGIN);
   check_mem(8'h50, image[3], "swap store 1");
   check_mem(8'h40, 8'h50, "swap store 2");
   check_mem(8'h60, 8'h40, "swap store 3");
   check_mem(image[3], 8'h60, "swap store 4");
endtask

task automatic test_stack();
   up_op_e     seq [11];
   logic [7:0] loop_pc;
   seq = '{OP_PUSH, OP_LDW, OP_PUSH, OP_SW12, OP_POP, OP_POP, OP_STW, OP_SW23, OP_SW01,
           OP_SW12, OP_LDW};
   new_image(8'h5C, 8'hC5, 8'h00, 8'h70);
   image[8'h70] = 8'hE7;
   foreach (seq[i])
      emit(seq[i]);
   loop_pc        = 8'(npc);
   image[2]       = loop_pc;
   image[loop_pc] = 8'h70;
   emit(OP_BE);
   start_image();
   wait_cycles(run_len + MARGIN);
   check_mem(8'hFF, loop_pc, "first push");
   check_mem(8'hFE, 8'hE7, "second push of loaded word");
   check_mem(8'h70, loop_pc, "popped value");
endtask

task automatic test_branches();
   up_op_e     seq [10];
   logic [7:0] loop_pc;
   logic [7:0] sub_pc;
   seq = '{OP_BE, OP_STW, OP_SW12, OP_LDW, OP_PUSHC, OP_BE, OP_SW23, OP_STW, OP_SW12, OP_LDW};
   new_image(8'h00, 8'h77, 8'h00, 8'h00);
   foreach (seq[i])
      emit(seq[i]);
   loop_pc = 8'(npc);
   emit(OP_BE);
   sub_pc = 8'(npc);
   emit(OP_ADD);
   emit(OP_SW01);
   emit(OP_SW12);
   emit(OP_STW);
   emit(OP_POPC);
   // The subroutine doubles r2, so r2 starts at half the loop pc.
   image[2] = loop_pc >> 1;
   image[3] = sub_pc;
   start_image();
   wait_cycles(run_len + MARGIN);
   check_mem(sub_pc, loop_pc, "subroutine marker");
   check_mem(loop_pc, sub_pc, "return path marker");
   check_mem(8'hFF, PC_RESET + 8'd5, "pushed return pc");
endtask

task automatic test_interrupts();
   logic [7:0] wait_pc;
   logic [7:0] loop_pc;
   new_image(8'h00, 8'h00, 8'h00, 8'h00);
   emit(OP_INT);
   wait_pc = 8'(npc);
   emit(OP_BE);
   emit(OP_SW23);
   emit(OP_STW);
   emit(OP_SW12);
   emit(OP_LDW);
   loop_pc = 8'(npc);
   emit(OP_BE);
   // Handler code lives in the upper half, from nibble pc 0.
   code_base = MEM_SIZE / 2;
   npc       = int'(INT_VECTOR);
   emit(OP_ADD);
   emit(OP_SW01);
   emit(OP_SW12);
   emit(OP_STW);
   emit(OP_POPC);
   image[1] = loop_pc >> 1;
   image[2] = loop_pc >> 1;
   image[3] = wait_pc;
   start_image();
   // The first edge spans the fetch of INT, while the interrupt is still disabled.
   wait_cycles(2);
   int_req <= 1'b1;
   wait_cycles(4);
   int_req <= 1'b0;
   wait_cycles(13);
   int_req <= 1'b1;
   wait_cycles(2);
   int_req <= 1'b0;
   wait_cycles(run_len + 5 + MARGIN);
   check_mem(8'hFF, wait_pc, "pc saved on interrupt");
   check_mem(wait_pc, loop_pc, "handler marker");
   check_mem(loop_pc, wait_pc, "main line marker");
endtask

task automatic test_ref_host();
   logic [7:0] d;
   new_image(8'h3A, 8'h11, 8'h22, 8'h00);
   emit(OP_ADD);
   emit(OP_REF);
   emit(OP_SW01);
   emit(OP_SW12);
   emit(OP_STW);
   emit(OP_SW12);
   emit(OP_LDW);
   image[3] = 8'(npc);
   emit(OP_BE);
   start_image();
   wait_cycles(run_len + MARGIN);
   check_mem(image[3], 8'h3A, "r0 after REF");
   host_read(8'h04, d);
   check_op("opcode at nibble 8", up_op_e'(d[7:4]), OP_ADD);
   check_op("opcode at nibble 9", up_op_e'(d[3:0]), OP_REF);
   for (int i = 0; i < 4; i++) begin
      host_write(8'hA0 + 8'(i), (8'hA0 + 8'(i)) ^ 8'h5A);
      check_mem(8'hA0 + 8'(i), (8'hA0 + 8'(i)) ^ 8'h5A, "host port readback");
   end
endtask

//--- dv/up_core_tb.sv
`timescale 1ns/1ps

module up_core_tb
   import up_isa_pkg::*;
();

   localparam int CLK_HALF     = 50;
   localparam int RESET_CYCLES = 4;
   localparam int MARGIN       = 16;
   localparam int RUNS         = 9;
   localparam int RUN_CYCLES   = MEM_SIZE + 160;
   localparam int WATCHDOG_NS  = (RUNS * RUN_CYCLES + 400) * 2 * CLK_HALF;

   logic              clk;
   logic              nRst;
   logic              int_req;
   logic              mem_map_load;
   logic [DATA_W-1:0] mem_map_address;
   logic [DATA_W-1:0] mem_map_in;
   logic [DATA_W-1:0] mem_map_out;

   // Memory image that the next run loads through the host port.
   logic [DATA_W-1:0] image [MEM_SIZE];
   int                npc;
   int                code_base;
   int                run_len;
   int                errors;
   int                checks;
   integer            seed;

   up_core uut (.clk, .nRst, .int_req, .mem_map_load, .mem_map_address, .mem_map_in,
                .mem_map_out);

   initial clk = 1'b0;
   always #(CLK_HALF) clk = ~clk;

   //////////////////////////////
   // Program image
   //////////////////////////////

   function automatic int op_cycles(up_op_e op);
      case (op)
         OP_ADD, OP_SUB, OP_MUL, OP_NAND, OP_BE, OP_INT: return 3;
         OP_POPC, OP_POP, OP_LDW, OP_STW, OP_REF:        return 4;
         default:                                        return 5;
      endcase
   endfunction

   task automatic new_image(input logic [7:0] b0, b1, b2, b3);
      for (int i = 0; i < MEM_SIZE; i++)
         image[i] = 8'(i) ^ 8'hA5;
      image[0]  = b0;
      image[1]  = b1;
      image[2]  = b2;
      image[3]  = b3;
      npc       = int'(PC_RESET);
      code_base = 0;
      run_len   = 5;
   endtask

   // The high nibble of a byte runs first.
   task automatic emit(input up_op_e op);
      int b;
      b = code_base + npc / 2;
      if (npc % 2 == 0)
         image[b][7:4] = op;
      else
         image[b][3:0] = op;
      npc++;
      run_len += op_cycles(op);
   endtask

   task automatic start_image();
      @(posedge clk);
      nRst    <= 1'b0;
      int_req <= 1'b0;
      for (int i = 0; i < MEM_SIZE; i++) begin
         @(posedge clk);
         mem_map_load    <= 1'b1;
         mem_map_address <= 8'(i);
         mem_map_in      <= image[i];
      end
      @(posedge clk);
      mem_map_load <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      nRst <= 1'b1;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic host_write(input logic [7:0] a, input logic [7:0] d);
      @(posedge clk);
      mem_map_load    <= 1'b1;
      mem_map_address <= a;
      mem_map_in      <= d;
      @(posedge clk);
      mem_map_load <= 1'b0;
   endtask

   task automatic host_read(input logic [7:0] a, output logic [7:0] d);
      @(posedge clk);
      mem_map_address <= a;
      @(negedge clk);
      d = mem_map_out;
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
      end
   endtask

   task automatic check_op(input string what, input up_op_e got, input up_op_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                  exp.name());
      end
   endtask

   task automatic check_mem(input logic [7:0] a, input logic [7:0] exp, input string what);
      logic [7:0] d;
      host_read(a, d);
      check_byte(what, d, exp);
   endtask

`include "up_core_tests.svh"

   initial begin
      seed            = 32'h36914db6;
      errors          = 0;
      checks          = 0;
      nRst            = 1'b0;
      int_req         = 1'b0;
      mem_map_load    = 1'b0;
      mem_map_address = '0;
      mem_map_in      = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      nRst <= 1'b1;
      test_alu();
      test_swaps();
      test_stack();
      test_branches();
      test_interrupts();
      test_ref_host();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+dv
common/up_isa_pkg.sv
common/up_ctrl_pkg.sv
verilog/up_memory.sv
up_core/up_sequencer.sv
up_core/up_regfile.sv
up_core/up_result_unit.sv
up_core/up_pointer_regs.sv
up_core/up_int_ctrl.sv
up_core/up_core.sv
dv/up_core_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f verilog.f --top-module up_core_tb -o up_core_tb
	./obj_dir/up_core_tb | tee /dev/stderr | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
